// ==== common/Core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

`define DATA_WIDTH 32  // RV32I datapath
`define REG_WIDTH  5   // Register number bits
`define REG_COUNT  32  // Including x0

`endif

// ==== common/Types.sv ====
package Types;

    typedef enum logic [6:0] {
        OpCode_Load   = 7'b0000011,
        OpCode_Store  = 7'b0100011,
        OpCode_Branch = 7'b1100011,
        OpCode_JAL    = 7'b1101111,
        OpCode_JALR   = 7'b1100111,
        OpCode_OpIMM  = 7'b0010011,
        OpCode_Op     = 7'b0110011,
        OpCode_LUI    = 7'b0110111,
        OpCode_AUIPC  = 7'b0010111,
        OpCode_System = 7'b1110011
    } OpCode;

    // Low three bits follow funct3, bit 3 marks the funct7 variants
    typedef enum logic [3:0] {
        AluOp_Add  = 4'b0000,
        AluOp_Sll  = 4'b0001,
        AluOp_Slt  = 4'b0010,
        AluOp_Sltu = 4'b0011,
        AluOp_Xor  = 4'b0100,
        AluOp_Srl  = 4'b0101,
        AluOp_Or   = 4'b0110,
        AluOp_And  = 4'b0111,
        AluOp_Sub  = 4'b1000,
        AluOp_Sra  = 4'b1101
    } AluOp;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        OpCode      opcode;
    } RTypeFmt;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        OpCode       opcode;
    } ITypeFmt;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        OpCode      opcode;
    } STypeFmt;

    typedef union packed {
        RTypeFmt rType;
        ITypeFmt iType;
        STypeFmt sType;
    } Instruction;

endpackage

// ==== decoder/InstDecoder.sv ====
`timescale 1ns/1ps
`include "Core_params.svh"

module InstDecoder (
    input  Types::Instruction       i_Inst,      // Instruction word
    output Types::OpCode            o_OP,        // Major opcode
    output logic [`REG_WIDTH-1:0]   o_RS1,       // Source register 1
    output logic [`REG_WIDTH-1:0]   o_RS2,       // Source register 2
    output logic [`REG_WIDTH-1:0]   o_RD,        // Destination register
    output logic [2:0]              o_Funct3,    // Branch condition or access width
    output logic [`DATA_WIDTH-1:0]  o_IMM,       // Extended immediate
    output Types::AluOp             o_AluOp,     // ALU operation
    output logic                    o_IsLoad,    // LOAD instruction
    output logic                    o_IsALU,     // OP or OP-IMM instruction
    output logic                    o_IsECALL,   // ECALL instruction
    output logic                    o_IsEBREAK); // EBREAK instruction

    import Types::*;

    logic [31:0]             word;   // Raw view for the U, J and B formats
    logic [`DATA_WIDTH-1:0]  immI;
    logic [`DATA_WIDTH-1:0]  immS;
    logic                    isOp;
    logic                    isOpImm;
    logic                    isSystem;

    assign word     = i_Inst;
    assign isOp     = i_Inst.rType.opcode == OpCode_Op;
    assign isOpImm  = i_Inst.rType.opcode == OpCode_OpIMM;
    assign isSystem = i_Inst.rType.opcode == OpCode_System;

    assign immI = {{(`DATA_WIDTH-12){i_Inst.iType.imm12[11]}}, i_Inst.iType.imm12};
    assign immS = {{(`DATA_WIDTH-12){i_Inst.sType.immHi[6]}},
                   i_Inst.sType.immHi, i_Inst.sType.immLo};

    always_comb begin
        case (i_Inst.iType.opcode)
            OpCode_LUI,
            OpCode_AUIPC:
                o_IMM = {word[31:12], 12'b0};
            OpCode_JAL:
                o_IMM = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
            OpCode_Branch:
                o_IMM = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
            OpCode_Store:
                o_IMM = immS;
            OpCode_OpIMM:
                if (i_Inst.iType.funct3[1:0] == 2'b01)
                    o_IMM = {{(`DATA_WIDTH-5){1'b0}}, i_Inst.iType.imm12[4:0]}; // Shamt only
                else
                    o_IMM = immI;
            OpCode_Load,
            OpCode_JALR,
            OpCode_System:
                o_IMM = immI;
            default:
                o_IMM = '0;
        endcase
    end

    // funct7 bit 5 picks SUB for register ops and SRA for both shift forms
    always_comb begin
        o_AluOp = AluOp_Add;
        if (isOp || isOpImm) begin
            case (i_Inst.rType.funct3)
                3'b000:  o_AluOp = (isOp && i_Inst.rType.funct7[5]) ? AluOp_Sub : AluOp_Add;
                3'b001:  o_AluOp = AluOp_Sll;
                3'b010:  o_AluOp = AluOp_Slt;
                3'b011:  o_AluOp = AluOp_Sltu;
                3'b100:  o_AluOp = AluOp_Xor;
                3'b101:  o_AluOp = i_Inst.rType.funct7[5] ? AluOp_Sra : AluOp_Srl;
                3'b110:  o_AluOp = AluOp_Or;
                default: o_AluOp = AluOp_And;
            endcase
        end
    end

    assign o_OP     = i_Inst.rType.opcode;
    assign o_RS1    = i_Inst.rType.rs1;
    assign o_RS2    = i_Inst.rType.rs2;
    assign o_RD     = i_Inst.rType.rd;
    assign o_Funct3 = i_Inst.rType.funct3;

    assign o_IsLoad   = i_Inst.rType.opcode == OpCode_Load;
    assign o_IsALU    = isOp | isOpImm;
    assign o_IsECALL  = isSystem && (i_Inst.iType.funct3 == 3'b000)
                        && (i_Inst.iType.imm12 == 12'h000);
    assign o_IsEBREAK = isSystem && (i_Inst.iType.funct3 == 3'b000)
                        && (i_Inst.iType.imm12 == 12'h001);

endmodule

// ==== exec/Alu.sv ====
`timescale 1ns/1ps
`include "Core_params.svh"

module Alu (
    input  Types::AluOp             i_Op,      // Operation
    input  logic [`DATA_WIDTH-1:0]  i_A,       // Operand A
    input  logic [`DATA_WIDTH-1:0]  i_B,       // Operand B
    output logic [`DATA_WIDTH-1:0]  o_Result,  // Operation result
    output logic                    o_Eq,      // A equals B
    output logic                    o_Lt,      // A less than B, signed
    output logic                    o_Ltu);    // A less than B, unsigned

    import Types::*;

    logic [4:0] shamt;

    assign shamt = i_B[4:0];

    assign o_Eq  = i_A == i_B;
    assign o_Lt  = $signed(i_A) < $signed(i_B);
    assign o_Ltu = i_A < i_B;

    always_comb begin
        case (i_Op)
            AluOp_Add:  o_Result = i_A + i_B;
            AluOp_Sub:  o_Result = i_A - i_B;
            AluOp_Sll:  o_Result = i_A << shamt;
            AluOp_Slt:  o_Result = {{(`DATA_WIDTH-1){1'b0}}, o_Lt};
            AluOp_Sltu: o_Result = {{(`DATA_WIDTH-1){1'b0}}, o_Ltu};
            AluOp_Xor:  o_Result = i_A ^ i_B;
            AluOp_Srl:  o_Result = i_A >> shamt;
            AluOp_Sra:  o_Result = $unsigned($signed(i_A) >>> shamt);  // Keeps the sign
            AluOp_Or:   o_Result = i_A | i_B;
            AluOp_And:  o_Result = i_A & i_B;
            default:    o_Result = '0;
        endcase
    end

endmodule

// ==== exec/ExecStage.sv ====
`timescale 1ns/1ps
`include "Core_params.svh"

module ExecStage (
    input  logic                    i_Clock,
    input  logic                    i_rst,
    input  logic                    i_Valid,         // Decoded instruction strobe
    input  logic [`DATA_WIDTH-1:0]  i_PC,
    input  Types::OpCode            i_OP,
    input  logic [2:0]              i_Funct3,
    input  logic [`REG_WIDTH-1:0]   i_RD,
    input  logic [`DATA_WIDTH-1:0]  i_IMM,
    input  Types::AluOp             i_AluOp,
    input  logic                    i_IsLoad,
    input  logic                    i_IsALU,
    input  logic                    i_IsECALL,
    input  logic                    i_IsEBREAK,
    input  logic [`DATA_WIDTH-1:0]  i_Rs1Data,
    input  logic [`DATA_WIDTH-1:0]  i_Rs2Data,
    output logic                    o_WrEn,          // Register file write port
    output logic [`REG_WIDTH-1:0]   o_WrAddr,
    output logic [`DATA_WIDTH-1:0]  o_WrData,
    output logic                    o_ResultValid,
    output logic [`REG_WIDTH-1:0]   o_Rd,
    output logic [`DATA_WIDTH-1:0]  o_Result,
    output logic                    o_RedirectValid,
    output logic [`DATA_WIDTH-1:0]  o_Target,
    output logic                    o_MemValid,
    output logic                    o_MemIsStore,
    output logic [`DATA_WIDTH-1:0]  o_MemAddr,
    output logic [`DATA_WIDTH-1:0]  o_MemWData,
    output logic                    o_TrapValid,
    output logic                    o_TrapIsEcall);

    import Types::*;

    // Execute register
    logic                    exValid;
    logic [`DATA_WIDTH-1:0]  exPc;
    OpCode                   exOp;
    logic [2:0]              exFunct3;
    logic [`REG_WIDTH-1:0]   exRd;
    logic [`DATA_WIDTH-1:0]  exImm;
    AluOp                    exAluOp;
    logic                    exIsLoad;
    logic                    exIsAlu;
    logic                    exIsEcall;
    logic                    exIsEbreak;
    logic [`DATA_WIDTH-1:0]  exRs1;
    logic [`DATA_WIDTH-1:0]  exRs2;

    logic [`DATA_WIDTH-1:0]  aluB;
    logic [`DATA_WIDTH-1:0]  aluResult;
    logic                    eq;
    logic                    lt;
    logic                    ltu;
    logic [`DATA_WIDTH-1:0]  pcPlusImm;
    logic [`DATA_WIDTH-1:0]  pcPlus4;
    logic                    writes;
    logic                    isJump;
    logic                    isStore;
    logic                    taken;
    logic [`DATA_WIDTH-1:0]  target;

    always_ff @(posedge i_Clock) begin
        if (i_rst)
            exValid <= 1'b0;
        else
            exValid <= i_Valid;
    end

    always_ff @(posedge i_Clock) begin
        if (i_Valid) begin
            exPc       <= i_PC;
            exOp       <= i_OP;
            exFunct3   <= i_Funct3;
            exRd       <= i_RD;
            exImm      <= i_IMM;
            exAluOp    <= i_AluOp;
            exIsLoad   <= i_IsLoad;
            exIsAlu    <= i_IsALU;
            exIsEcall  <= i_IsECALL;
            exIsEbreak <= i_IsEBREAK;
            exRs1      <= i_Rs1Data;
            exRs2      <= i_Rs2Data;
        end
    end

    // Address forming ops go through the adder as well
    assign aluB = (exOp inside {OpCode_OpIMM, OpCode_Load, OpCode_Store, OpCode_JALR})
                  ? exImm : exRs2;

    Alu alu (
        .i_Op     (exAluOp),
        .i_A      (exRs1),
        .i_B      (aluB),
        .o_Result (aluResult),
        .o_Eq     (eq),
        .o_Lt     (lt),
        .o_Ltu    (ltu));

    assign pcPlusImm = exPc + exImm;
    assign pcPlus4   = exPc + `DATA_WIDTH'(4);
    assign isJump    = exOp inside {OpCode_JAL, OpCode_JALR};
    assign isStore   = exOp == OpCode_Store;
    assign writes    = exIsAlu || isJump || (exOp inside {OpCode_LUI, OpCode_AUIPC});

    always_comb begin
        case (exOp)
            OpCode_LUI:   o_WrData = exImm;
            OpCode_AUIPC: o_WrData = pcPlusImm;
            OpCode_JAL,
            OpCode_JALR:  o_WrData = pcPlus4;      // Link value
            default:      o_WrData = aluResult;
        endcase
    end

    always_comb begin
        taken = 1'b0;
        if (exOp == OpCode_Branch) begin
            case (exFunct3)
                3'b000:  taken = eq;
                3'b001:  taken = !eq;
                3'b100:  taken = lt;
                3'b101:  taken = !lt;
                3'b110:  taken = ltu;
                3'b111:  taken = !ltu;
                default: taken = 1'b0;
            endcase
        end
    end

    assign target = (exOp == OpCode_JALR) ? {aluResult[`DATA_WIDTH-1:1], 1'b0} : pcPlusImm;

    assign o_WrEn   = exValid && writes && (exRd != '0);  // x0 is never written
    assign o_WrAddr = exRd;

    always_ff @(posedge i_Clock) begin
        if (i_rst) begin
            o_ResultValid   <= 1'b0;
            o_RedirectValid <= 1'b0;
            o_MemValid      <= 1'b0;
            o_TrapValid     <= 1'b0;
        end else begin
            o_ResultValid   <= o_WrEn;
            o_RedirectValid <= exValid && (isJump || taken);
            o_MemValid      <= exValid && (exIsLoad || isStore);
            o_TrapValid     <= exValid && (exIsEcall || exIsEbreak);
        end
    end

    always_ff @(posedge i_Clock) begin
        o_Rd          <= exRd;
        o_Result      <= o_WrData;
        o_Target      <= target;
        o_MemIsStore  <= isStore;
        o_MemAddr     <= aluResult;   // rs1 plus immediate
        o_MemWData    <= exRs2;
        o_TrapIsEcall <= exIsEcall;
    end

endmodule

// ==== rtl/RegisterFile.sv ====
`timescale 1ns/1ps
`include "Core_params.svh"

module RegisterFile (
    input  logic                    i_Clock,
    input  logic                    i_rst,
    input  logic [`REG_WIDTH-1:0]   i_RdAddrA,   // Read port A address
    input  logic [`REG_WIDTH-1:0]   i_RdAddrB,   // Read port B address
    input  logic                    i_WrEn,
    input  logic [`REG_WIDTH-1:0]   i_WrAddr,
    input  logic [`DATA_WIDTH-1:0]  i_WrData,
    output logic [`DATA_WIDTH-1:0]  o_RdDataA,
    output logic [`DATA_WIDTH-1:0]  o_RdDataB);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    // Read with x0 forced to zero and the pending write bypassed
    function automatic logic [`DATA_WIDTH-1:0] readPort(input logic [`REG_WIDTH-1:0] addr);
        if (addr == '0)
            return '0;
        else if (i_WrEn && (addr == i_WrAddr))
            return i_WrData;
        else
            return regs[addr];
    endfunction

    always_ff @(posedge i_Clock) begin
        if (i_rst) begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end else if (i_WrEn && (i_WrAddr != '0)) begin
            regs[i_WrAddr] <= i_WrData;
        end
    end

    always_comb begin
        o_RdDataA = readPort(i_RdAddrA);
        o_RdDataB = readPort(i_RdAddrB);
    end

endmodule

// ==== rtl/RvExecCore.sv ====
`timescale 1ns/1ps
`include "Core_params.svh"

module RvExecCore (
    input  logic                    i_Clock,
    input  logic                    i_rst,
    input  logic                    i_InstValid,     // One instruction per strobe
    input  Types::Instruction       i_Inst,
    input  logic [`DATA_WIDTH-1:0]  i_PC,
    output logic                    o_ResultValid,
    output logic [`REG_WIDTH-1:0]   o_Rd,
    output logic [`DATA_WIDTH-1:0]  o_Result,
    output logic                    o_RedirectValid,
    output logic [`DATA_WIDTH-1:0]  o_Target,
    output logic                    o_MemValid,
    output logic                    o_MemIsStore,
    output logic [`DATA_WIDTH-1:0]  o_MemAddr,
    output logic [`DATA_WIDTH-1:0]  o_MemWData,
    output logic                    o_TrapValid,
    output logic                    o_TrapIsEcall);

    import Types::*;

    OpCode                   decOp;
    logic [`REG_WIDTH-1:0]   decRs1;
    logic [`REG_WIDTH-1:0]   decRs2;
    logic [`REG_WIDTH-1:0]   decRd;
    logic [2:0]              decFunct3;
    logic [`DATA_WIDTH-1:0]  decImm;
    AluOp                    decAluOp;
    logic                    decIsLoad;
    logic                    decIsAlu;
    logic                    decIsEcall;
    logic                    decIsEbreak;
    logic [`DATA_WIDTH-1:0]  rs1Data;
    logic [`DATA_WIDTH-1:0]  rs2Data;
    logic                    wrEn;
    logic [`REG_WIDTH-1:0]   wrAddr;
    logic [`DATA_WIDTH-1:0]  wrData;

    InstDecoder decoder (
        .i_Inst     (i_Inst),
        .o_OP       (decOp),
        .o_RS1      (decRs1),
        .o_RS2      (decRs2),
        .o_RD       (decRd),
        .o_Funct3   (decFunct3),
        .o_IMM      (decImm),
        .o_AluOp    (decAluOp),
        .o_IsLoad   (decIsLoad),
        .o_IsALU    (decIsAlu),
        .o_IsECALL  (decIsEcall),
        .o_IsEBREAK (decIsEbreak));

    RegisterFile regFile (
        .i_Clock   (i_Clock),
        .i_rst     (i_rst),
        .i_RdAddrA (decRs1),
        .i_RdAddrB (decRs2),
        .i_WrEn    (wrEn),
        .i_WrAddr  (wrAddr),
        .i_WrData  (wrData),
        .o_RdDataA (rs1Data),
        .o_RdDataB (rs2Data));

    ExecStage exec (
        .i_Clock         (i_Clock),
        .i_rst           (i_rst),
        .i_Valid         (i_InstValid),
        .i_PC            (i_PC),
        .i_OP            (decOp),
        .i_Funct3        (decFunct3),
        .i_RD            (decRd),
        .i_IMM           (decImm),
        .i_AluOp         (decAluOp),
        .i_IsLoad        (decIsLoad),
        .i_IsALU         (decIsAlu),
        .i_IsECALL       (decIsEcall),
        .i_IsEBREAK      (decIsEbreak),
        .i_Rs1Data       (rs1Data),
        .i_Rs2Data       (rs2Data),
        .o_WrEn          (wrEn),
        .o_WrAddr        (wrAddr),
        .o_WrData        (wrData),
        .o_ResultValid   (o_ResultValid),
        .o_Rd            (o_Rd),
        .o_Result        (o_Result),
        .o_RedirectValid (o_RedirectValid),
        .o_Target        (o_Target),
        .o_MemValid      (o_MemValid),
        .o_MemIsStore    (o_MemIsStore),
        .o_MemAddr       (o_MemAddr),
        .o_MemWData      (o_MemWData),
        .o_TrapValid     (o_TrapValid),
        .o_TrapIsEcall   (o_TrapIsEcall));

endmodule

// ==== verif/RvExecCore_chk.sv ====
`timescale 1ns/1ps
`include "Core_params.svh"

module RvExecCore_chk (
    input logic                   i_Clock,
    input logic                   i_rst,
    input logic                   i_ResultValid,
    input logic [`REG_WIDTH-1:0]  i_Rd,
    input logic                   i_RedirectValid,
    input logic                   i_MemValid,
    input logic                   i_TrapValid);

    noWriteToX0: assert property (@(posedge i_Clock) disable iff (i_rst)
        i_ResultValid |-> i_Rd != '0)
        else $error("result strobe with rd x0");

    trapAlone: assert property (@(posedge i_Clock) disable iff (i_rst)
        i_TrapValid |-> !(i_ResultValid || i_MemValid))
        else $error("trap strobe together with result or memory strobe");

    quietAfterReset: assert property (@(posedge i_Clock)
        i_rst |=> !(i_ResultValid || i_RedirectValid || i_MemValid || i_TrapValid))
        else $error("output strobe high right after reset");

endmodule

bind RvExecCore RvExecCore_chk chk (
    .i_Clock         (i_Clock),
    .i_rst           (i_rst),
    .i_ResultValid   (o_ResultValid),
    .i_Rd            (o_Rd),
    .i_RedirectValid (o_RedirectValid),
    .i_MemValid      (o_MemValid),
    .i_TrapValid     (o_TrapValid));

// ==== verif/tb_RvExecCore.sv ====
`timescale 1ns/1ps

module tb_RvExecCore;

    import Types::*;

    localparam int NumInsts = 130;
    localparam logic [31:0] LfsrTaps = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1

    typedef struct packed {
        int          due;
        bit          res;
        bit [4:0]    rd;
        bit [31:0]   result;
        bit          redir;
        bit [31:0]   target;
        bit          mem;
        bit          store;
        bit [31:0]   addr;
        bit [31:0]   wdata;
        bit          trap;
        bit          ecall;
    } Expect;

    logic        clock = 1'b0;
    logic        rst;
    logic        instValid;
    Instruction  inst;
    logic [31:0] pc;
    logic        resultValid, redirectValid, memValid, memIsStore, trapValid, trapIsEcall;
    logic [4:0]  rd;
    logic [31:0] result, target, memAddr, memWData;

    logic [31:0] regs [32];    // Reference register model
    logic [31:0] lfsr = 32'h6553_237c;
    logic [31:0] pcNext = 32'h0000_1000;
    Expect       pending [$];
    int          cyc = 0;
    int          checks = 0;
    int          errors = 0;
    int          tests = 0;
    string       testName = "reset";

    RvExecCore dut (
        .i_Clock(clock), .i_rst(rst), .i_InstValid(instValid), .i_Inst(inst), .i_PC(pc),
        .o_ResultValid(resultValid), .o_Rd(rd), .o_Result(result),
        .o_RedirectValid(redirectValid), .o_Target(target),
        .o_MemValid(memValid), .o_MemIsStore(memIsStore), .o_MemAddr(memAddr),
        .o_MemWData(memWData), .o_TrapValid(trapValid), .o_TrapIsEcall(trapIsEcall));

    always #5 clock = ~clock;

    always @(posedge clock) cyc <= cyc + 1;

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        logic        lsb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lsb  = lfsr[0];
            lfsr = lsb ? ((lfsr >> 1) ^ LfsrTaps) : (lfsr >> 1);
            val  = {val[30:0], lsb};
        end
        return val;
    endfunction

    // Random register in x1..x8
    function automatic logic [4:0] randReg();
        return 5'(randBits(3)) + 5'd1;
    endfunction

    function automatic logic [31:0] refAlu(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // Expected record for a register write, model updated in program order
    function automatic Expect wrote(input logic [4:0] r, input logic [31:0] v);
        Expect e;
        e = '0;
        e.res = r != 0;
        e.rd = r;
        e.result = v;
        if (r != 0)
            regs[r] = v;
        return e;
    endfunction

    task automatic checkEq(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            $display("ERR %s %s: expected %h, actual %h", testName, what, exp, act);
            errors++;
        end
    endtask

    task automatic send(input Instruction word, input Expect e);
        @(posedge clock);
        e.due = cyc + 3;  // Output edge is the second edge after the sampling edge
        pending.push_back(e);
        instValid <= 1'b1;
        inst      <= word;
        pc        <= pcNext;
        pcNext     = pcNext + 4;
    endtask

    task automatic drain();
        int n;
        @(posedge clock);
        instValid <= 1'b0;
        for (n = 0; n < 20 && pending.size() > 0; n++)
            @(posedge clock);
        if (pending.size() > 0) begin
            $display("%s: expected responses never arrived", testName);
            errors++;
            pending.delete();
        end
    endtask

    task automatic opReg(input logic [2:0] f3, input logic alt, input logic [4:0] d,
                         input logic [4:0] s1, input logic [4:0] s2);
        Instruction w;
        w.rType = '{alt ? 7'h20 : 7'h00, s2, s1, f3, d, OpCode_Op};
        send(w, wrote(d, refAlu(f3, alt, regs[s1], regs[s2])));
    endtask

    task automatic opImm(input logic [2:0] f3, input logic [4:0] d, input logic [4:0] s1,
                         input logic [11:0] imm);
        Instruction  w;
        logic [31:0] b;
        b = (f3 == 3'd1 || f3 == 3'd5) ? {27'b0, imm[4:0]} : sext12(imm);
        w.iType = '{imm, s1, f3, d, OpCode_OpIMM};
        send(w, wrote(d, refAlu(f3, f3 == 3'd5 && imm[10], regs[s1], b)));
    endtask

    task automatic upper(input logic isAuipc, input logic [4:0] d, input logic [19:0] imm);
        Instruction w;
        w = {imm, d, isAuipc ? OpCode_AUIPC : OpCode_LUI};
        send(w, wrote(d, isAuipc ? pcNext + {imm, 12'b0} : {imm, 12'b0}));
    endtask

    task automatic jal(input logic [4:0] d, input logic [20:0] off);
        Instruction w;
        Expect      e;
        w = {off[20], off[10:1], off[11], off[19:12], d, OpCode_JAL};
        e = wrote(d, pcNext + 4);
        e.redir = 1'b1;
        e.target = pcNext + {{11{off[20]}}, off};
        send(w, e);
    endtask

    task automatic jalr(input logic [4:0] d, input logic [4:0] s1, input logic [11:0] imm);
        Instruction  w;
        Expect       e;
        logic [31:0] tgt;
        tgt = (regs[s1] + sext12(imm)) & ~32'd1;  // Read before the link write
        w.iType = '{imm, s1, 3'b000, d, OpCode_JALR};
        e = wrote(d, pcNext + 4);
        e.redir = 1'b1;
        e.target = tgt;
        send(w, e);
    endtask

    task automatic branch(input logic [2:0] f3, input logic [4:0] s1, input logic [4:0] s2,
                          input logic [12:0] off);
        Instruction  w;
        Expect       e;
        logic [31:0] slt;
        slt = refAlu(3'd2, 1'b0, regs[s1], regs[s2]);
        e = '0;
        case (f3)
            3'd0:    e.redir = regs[s1] == regs[s2];
            3'd1:    e.redir = regs[s1] != regs[s2];
            3'd4:    e.redir = slt[0];
            3'd5:    e.redir = !slt[0];
            3'd6:    e.redir = regs[s1] < regs[s2];
            default: e.redir = regs[s1] >= regs[s2];
        endcase
        e.target = pcNext + {{19{off[12]}}, off};
        w = {off[12], off[10:5], s2, s1, f3, off[4:1], off[11], OpCode_Branch};
        send(w, e);
    endtask

    task automatic memOp(input logic isStore, input logic [4:0] s1, input logic [4:0] r,
                         input logic [11:0] imm);
        Instruction w;
        Expect      e;
        e = '0;
        e.mem = 1'b1;
        e.store = isStore;
        e.addr = regs[s1] + sext12(imm);
        e.wdata = regs[r];
        if (isStore)
            w.sType = '{imm[11:5], r, s1, 3'b010, imm[4:0], OpCode_Store};
        else
            w.iType = '{imm, s1, 3'b010, r, OpCode_Load};
        send(w, e);
    endtask

    task automatic sys(input logic isEcall);
        Instruction w;
        Expect      e;
        e = '0;
        e.trap = 1'b1;
        e.ecall = isEcall;
        w.iType = '{isEcall ? 12'h000 : 12'h001, 5'd0, 3'b000, 5'd0, OpCode_System};
        send(w, e);
    endtask

    task automatic finishTest(input int startErrors);
        drain();
        tests++;
        $display("%s: %s", testName, errors == startErrors ? "ok" : "failed");
    endtask

    always @(negedge clock) begin
        Expect e;
        if (!rst) begin
            if (pending.size() > 0 && pending[0].due == cyc) begin
                e = pending.pop_front();
                checkEq("result valid", 32'(e.res), 32'(resultValid));
                checkEq("redirect valid", 32'(e.redir), 32'(redirectValid));
                checkEq("mem valid", 32'(e.mem), 32'(memValid));
                checkEq("trap valid", 32'(e.trap), 32'(trapValid));
                if (e.res && resultValid) begin
                    checkEq("rd", 32'(e.rd), 32'(rd));
                    checkEq("result", e.result, result);
                end
                if (e.redir && redirectValid)
                    checkEq("target", e.target, target);
                if (e.mem && memValid) begin
                    checkEq("mem is store", 32'(e.store), 32'(memIsStore));
                    checkEq("mem addr", e.addr, memAddr);
                    if (e.store)
                        checkEq("mem wdata", e.wdata, memWData);
                end
                if (e.trap && trapValid)
                    checkEq("trap is ecall", 32'(e.ecall), 32'(trapIsEcall));
            end else begin
                checkEq("idle strobes", 0,
                        32'({resultValid, redirectValid, memValid, trapValid}));
            end
        end
    end

    task automatic testAlu();
        int         startErrors;
        logic [2:0] immOps [6] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
        startErrors = errors;
        testName = "alu";
        for (int r = 1; r <= 8; r++) begin
            upper(1'b0, 5'(r), 20'(randBits(20)));
            opImm(3'd0, 5'(r), 5'(r), 12'(randBits(12)));
        end
        for (int f = 0; f < 8; f++)
            opReg(3'(f), 1'b0, randReg(), randReg(), randReg());
        opReg(3'd0, 1'b1, randReg(), randReg(), randReg());
        opReg(3'd5, 1'b1, randReg(), randReg(), randReg());
        foreach (immOps[i])
            opImm(immOps[i], randReg(), randReg(), 12'(randBits(12)));
        opImm(3'd1, randReg(), randReg(), {7'h00, 5'(randBits(5))});
        opImm(3'd5, randReg(), randReg(), {7'h00, 5'(randBits(5))});
        opImm(3'd5, randReg(), randReg(), {7'h20, 5'(randBits(5))});
        opReg(3'd0, 1'b0, 5'd0, 5'd1, 5'd2);  // Write to x0 gives no strobe
        finishTest(startErrors);
    endtask

    task automatic testChain();
        int startErrors;
        startErrors = errors;
        testName = "chain";
        opImm(3'd0, 9, 0, 12'(randBits(12)));
        opReg(3'd0, 1'b0, 10, 9, 9);
        opReg(3'd0, 1'b1, 11, 10, 9);
        opReg(3'd4, 1'b0, 9, 11, 10);
        opImm(3'd1, 10, 9, 12'h003);
        opReg(3'd5, 1'b1, 11, 10, 9);
        opReg(3'd2, 1'b0, 12, 11, 10);
        finishTest(startErrors);
    endtask

    task automatic testJump();
        int startErrors;
        startErrors = errors;
        testName = "jump";
        upper(1'b0, 13, 20'(randBits(20)));
        upper(1'b1, 14, 20'(randBits(20)));
        jal(1, 21'h000100);
        jal(0, 21'h1FFFF8);
        opImm(3'd0, 15, 0, 12'h123);
        jalr(1, 15, 12'h010);   // Odd sum, bit 0 cleared
        jalr(0, 13, 12'hFF5);
        finishTest(startErrors);
    endtask

    task automatic testBranch();
        int         startErrors;
        logic [2:0] conds [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        startErrors = errors;
        testName = "branch";
        opImm(3'd0, 16, 0, 12'hFFF);
        opImm(3'd0, 17, 0, 12'h001);
        opImm(3'd0, 18, 0, 12'h001);
        foreach (conds[i]) begin
            branch(conds[i], 17, 18, 13'h0040);
            branch(conds[i], 16, 17, 13'h1FF0);
        end
        finishTest(startErrors);
    endtask

    task automatic testMem();
        int startErrors;
        startErrors = errors;
        testName = "mem";
        memOp(1'b0, 16, 19, 12'h800);
        memOp(1'b1, 17, 16, 12'h7FC);
        memOp(1'b0, randReg(), 20, 12'(randBits(12)));
        memOp(1'b1, randReg(), randReg(), 12'(randBits(12)));
        finishTest(startErrors);
    endtask

    task automatic testTrapReset();
        int startErrors;
        startErrors = errors;
        testName = "trap_reset";
        sys(1'b1);
        sys(1'b0);
        drain();
        opImm(3'd0, 5'd1, 5'd0, 12'h001);   // Still in execute when reset arrives
        @(posedge clock);
        instValid <= 1'b0;
        rst       <= 1'b1;
        pending.delete();
        @(posedge clock);
        @(negedge clock);
        checkEq("strobes in reset", 0,
                32'({resultValid, redirectValid, memValid, trapValid}));
        @(posedge clock);
        rst <= 1'b0;
        foreach (regs[i])
            regs[i] = '0;
        for (int r = 1; r < 32; r++)
            opImm(3'd0, 5'(r), 5'(r), 12'h000);
        finishTest(startErrors);
    endtask

    initial begin
        rst       <= 1'b1;
        instValid <= 1'b0;
        inst      <= '0;
        pc        <= '0;
        foreach (regs[i])
            regs[i] = '0;
        repeat (2) @(posedge clock);
        rst <= 1'b0;
        testAlu();
        testChain();
        testJump();
        testBranch();
        testMem();
        testTrapReset();
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    // Each instruction takes a few cycles at most, plus reset and drain time
    initial begin
        #((NumInsts * 4 + 200) * 10);
        $display("Watchdog timeout, the run did not finish in time");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+common
common/Types.sv
decoder/InstDecoder.sv
exec/Alu.sv
exec/ExecStage.sv
rtl/RegisterFile.sv
rtl/RvExecCore.sv
verif/RvExecCore_chk.sv
verif/tb_RvExecCore.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the RvExecCore testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_RvExecCore -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

output=$(./obj_dir/Vtb_RvExecCore)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1
